//--- bench/xbar_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module xbar_clock_gen #(
	parameter realtime PERIOD = 20.0
)(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2.0) clk = ~clk;   // free running
	end

endmodule

`default_nettype wire

//--- bench/xbar_tb.sv
`timescale 1ns/1ps
`default_nettype none

module xbar_tb
	import xbar_pkg::*;
();

	localparam int DATA_WIDTH     = 32;
	localparam int N_TESTS        = 6;
	localparam int TIMEOUT_CYCLES = N_TESTS * (XBAR_LATENCY + 20) + 20;

	typedef logic [XBAR_N_IN-1:0][DATA_WIDTH-1:0]  in_lanes_t;
	typedef logic [XBAR_N_OUT-1:0][DATA_WIDTH-1:0] out_lanes_t;

	logic                  clk;
	logic                  arst_n;
	logic                  en;
	logic [XBAR_N_IN-1:0]  valid;
	in_lanes_t             data;
	xbar_cmd_u             cmd;
	logic [XBAR_N_OUT-1:0] out_valid;
	out_lanes_t            out_data;

	int errors       = 0;
	int tests_run    = 0;
	int tests_failed = 0;

	xbar_clock_gen #(.PERIOD(20.0)) i_clock_gen (.clk(clk));

	xbar_top #(
		.DATA_WIDTH(DATA_WIDTH)
	) i_xbar_top (
		.clk      (clk),
		.i_arst_n (arst_n),
		.i_en     (en),
		.i_valid  (valid),
		.i_data   (data),
		.i_cmd    (cmd),
		.o_valid  (out_valid),
		.o_data   (out_data)
	);

	function automatic in_lanes_t random_lanes();
		in_lanes_t lanes;
		for (int n = 0; n < XBAR_N_IN; n++)
			lanes[n] = $urandom();
		return lanes;
	endfunction

	function automatic xbar_cmd_u add_route(input xbar_cmd_u c, input int n, input int o);
		c.flat[n*XBAR_N_OUT + o] = 1'b1;
		return c;
	endfunction

	// reference routing: one-hot column per half, then exclusive merge
	function automatic void route_model(input logic [XBAR_N_IN-1:0] v, input in_lanes_t d,
		input xbar_cmd_u c, output logic [XBAR_N_OUT-1:0] exp_v, output out_lanes_t exp_d);
		logic [1:0]                 half_v;
		logic [1:0][DATA_WIDTH-1:0] half_d;
		int                         hits;
		int                         src;
		exp_v = '0;
		exp_d = '0;
		for (int o = 0; o < XBAR_N_OUT; o++)
		begin
			half_v = '0;
			half_d = '0;
			for (int h = 0; h < 2; h++)
			begin
				hits = 0;
				src  = 0;
				for (int k = 0; k < XBAR_N_HALF; k++)
				begin
					if (c.flat[(h*XBAR_N_HALF + k)*XBAR_N_OUT + o])
					begin
						hits++;
						src = h*XBAR_N_HALF + k;
					end
				end
				if (hits == 1 && v[src])
				begin
					half_v[h] = 1'b1;
					half_d[h] = d[src];
				end
			end
			if (half_v == 2'b01 || half_v == 2'b10)   // exactly one half
			begin
				exp_v[o] = 1'b1;
				exp_d[o] = half_v[0] ? half_d[0] : half_d[1];
			end
		end
	endfunction

	task automatic compare_valid(input logic [XBAR_N_OUT-1:0] exp,
		input logic [XBAR_N_OUT-1:0] act);
		if (act !== exp)
		begin
			$display("Mismatch o_valid: expected 0x%h, got 0x%h", exp, act);
			errors++;
		end
	endtask

	task automatic compare_data(input int idx, input logic [DATA_WIDTH-1:0] exp,
		input logic [DATA_WIDTH-1:0] act);
		if (act !== exp)
		begin
			$display("Mismatch o_data[%0d]: expected 0x%h, got 0x%h", idx, exp, act);
			errors++;
		end
	endtask

	task automatic check_expected(input logic [XBAR_N_IN-1:0] v, input in_lanes_t d,
		input xbar_cmd_u c);
		logic [XBAR_N_OUT-1:0] exp_v;
		out_lanes_t            exp_d;
		route_model(v, d, c, exp_v, exp_d);
		compare_valid(exp_v, out_valid);
		for (int o = 0; o < XBAR_N_OUT; o++)
			compare_data(o, exp_d[o], out_data[o]);
	endtask

	task automatic check_idle();
		compare_valid('0, out_valid);
		for (int o = 0; o < XBAR_N_OUT; o++)
			compare_data(o, '0, out_data[o]);
	endtask

	task automatic apply(input logic [XBAR_N_IN-1:0] v, input in_lanes_t d, input xbar_cmd_u c);
		valid = v;
		data  = d;
		cmd   = c;
	endtask

	// drive on the falling edge, return after the sampling edge
	task automatic launch(input logic [XBAR_N_IN-1:0] v, input in_lanes_t d, input xbar_cmd_u c);
		@(negedge clk);
		apply(v, d, c);
		@(posedge clk);
	endtask

	task automatic go_idle();
		@(negedge clk);
		apply('0, '0, '0);
	endtask

	task automatic send_and_check(input logic [XBAR_N_IN-1:0] v, input in_lanes_t d,
		input xbar_cmd_u c);
		launch(v, d, c);
		go_idle();
		repeat (XBAR_LATENCY - 1) @(posedge clk);
		@(negedge clk);
		check_expected(v, d, c);
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (errors != errs_before)
		begin
			tests_failed++;
			$display("%s: failed with %0d mismatches", name, errors - errs_before);
		end
		else
			$display("%s: passed", name);
	endtask

	task automatic test_reset();
		int        errs_before;
		xbar_cmd_u c;
		errs_before = errors;
		check_idle();   // straight out of reset
		c = '0;
		for (int k = 0; k < XBAR_N_OUT; k++)
			c = add_route(c, k, k);
		launch('1, random_lanes(), c);   // en still low
		go_idle();
		repeat (XBAR_LATENCY - 1) @(posedge clk);
		@(negedge clk);
		check_idle();
		finish_test("reset", errs_before);
	endtask

	task automatic test_permutation();
		int        errs_before;
		xbar_cmd_u c;
		errs_before = errors;
		c = '0;
		for (int k = 0; k < XBAR_N_HALF; k++)
			c = add_route(c, k, XBAR_N_OUT - 1 - k);   // reversed through half 0
		send_and_check('1, random_lanes(), c);
		c = '0;
		for (int k = 0; k < XBAR_N_HALF; k++)
			c = add_route(c, XBAR_N_HALF + k, (k + 3) % XBAR_N_OUT);
		send_and_check('1, random_lanes(), c);
		finish_test("permutation", errs_before);
	endtask

	task automatic test_multicast_conflict();
		int        errs_before;
		xbar_cmd_u c;
		errs_before = errors;
		c = '0;
		c.by_input[3] = '1;   // broadcast
		send_and_check('1, random_lanes(), c);
		c = '0;
		c = add_route(c, 0, 0);
		c = add_route(c, 1, 2);
		c = add_route(c, 5, 2);   // same-half clash
		send_and_check('1, random_lanes(), c);
		c = '0;
		c = add_route(c, 2, 4);
		c = add_route(c, 12, 4);   // cross-half clash
		c = add_route(c, 9, 6);
		send_and_check('1, random_lanes(), c);
		finish_test("multicast and conflict", errs_before);
	endtask

	task automatic test_invalid_source();
		int        errs_before;
		xbar_cmd_u c;
		errs_before = errors;
		c = '0;
		c = add_route(c, 6, 1);
		c = add_route(c, 10, 3);
		send_and_check(~(16'h1 << 6), random_lanes(), c);
		finish_test("invalid source", errs_before);
	endtask

	task automatic test_pipelining();
		int                   errs_before;
		logic [XBAR_N_IN-1:0] v [3];
		in_lanes_t            d [3];
		xbar_cmd_u            c [3];
		errs_before = errors;
		for (int i = 0; i < 3; i++)
		begin
			v[i] = XBAR_N_IN'($urandom());
			d[i] = random_lanes();
			c[i] = '0;
			for (int o = 0; o < XBAR_N_OUT; o++)
				c[i] = add_route(c[i], (o * 5 + i * 3) % XBAR_N_IN, o);
		end
		for (int i = 0; i < 3; i++)
			launch(v[i], d[i], c[i]);   // back to back
		go_idle();
		repeat (XBAR_LATENCY - 3) @(posedge clk);
		for (int i = 0; i < 3; i++)
		begin
			if (i > 0)
				@(posedge clk);
			@(negedge clk);
			check_expected(v[i], d[i], c[i]);
		end
		finish_test("pipelining", errs_before);
	endtask

	task automatic test_enable();
		int        errs_before;
		in_lanes_t d;
		xbar_cmd_u c;
		errs_before = errors;
		c = '0;
		for (int k = 0; k < XBAR_N_OUT; k++)
			c = add_route(c, k + 4, k);
		launch('1, random_lanes(), c);   // item dropped in flight
		go_idle();
		@(posedge clk);
		@(negedge clk);
		en = 1'b0;
		@(posedge clk);
		@(negedge clk);
		en = 1'b1;
		d = random_lanes();
		apply('1, d, c);
		@(posedge clk);
		go_idle();
		repeat (XBAR_LATENCY - 4) @(posedge clk);
		@(negedge clk);
		check_idle();
		repeat (3) @(posedge clk);
		@(negedge clk);
		check_expected('1, d, c);
		finish_test("enable", errs_before);
	endtask

	initial
	begin
		void'($urandom(81));
		arst_n = 1'b0;
		en     = 1'b0;
		apply('0, '0, '0);
		repeat (10) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		test_reset();
		@(negedge clk);
		en = 1'b1;
		test_permutation();
		test_multicast_conflict();
		test_invalid_source();
		test_pipelining();
		test_enable();
		$display("tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// watchdog
	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("run timed out after %0d clock cycles", TIMEOUT_CYCLES);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
source/xbar_pkg.sv
source/xbar_fanout_tree.sv
source/xbar_cmd_tree.sv
source/xbar_column_select.sv
source/xbar_half_merge.sv
source/xbar_top.sv
bench/xbar_clock_gen.sv
bench/xbar_tb.sv

//--- source/xbar_cmd_tree.sv
`timescale 1ns/1ps
`default_nettype none

module xbar_cmd_tree
	import xbar_pkg::*;
(
	input  logic                  clk,
	input  logic                  i_arst_n,
	input  logic                  i_en,
	input  logic [XBAR_N_OUT-1:0] i_mask,
	output logic [XBAR_N_OUT-1:0] o_sel
);

	genvar l;

	generate
		for (l = 0; l < XBAR_LEVELS; l++)
		begin : g_lvl
			localparam int PARTS = 1 << l;
			localparam int WIDTH = XBAR_N_OUT >> l;   // bits per part

			logic [PARTS-1:0][WIDTH-1:0] part_q;

			if (l == 0)
			begin : g_first
				always_ff @(posedge clk or negedge i_arst_n)
				begin
					if (!i_arst_n)
						part_q <= '0;
					else if (!i_en)
						part_q <= '0;
					else
						part_q[0] <= i_mask;   // whole mask
				end
			end
			else
			begin : g_split
				// lower and upper half of each parent part
				always_ff @(posedge clk or negedge i_arst_n)
				begin
					if (!i_arst_n)
						part_q <= '0;
					else if (!i_en)
						part_q <= '0;
					else
					begin
						for (int j = 0; j < PARTS / 2; j++)
						begin
							part_q[2*j]   <= g_lvl[l-1].part_q[j][WIDTH-1:0];
							part_q[2*j+1] <= g_lvl[l-1].part_q[j][2*WIDTH-1:WIDTH];
						end
					end
				end
			end
		end
	endgenerate

	// last split gives single bits, one per output
	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			o_sel <= '0;
		else if (!i_en)
			o_sel <= '0;
		else
		begin
			for (int j = 0; j < XBAR_N_OUT / 2; j++)
			begin
				o_sel[2*j]   <= g_lvl[XBAR_LEVELS-1].part_q[j][0];
				o_sel[2*j+1] <= g_lvl[XBAR_LEVELS-1].part_q[j][1];
			end
		end
	end

endmodule

`default_nettype wire

//--- source/xbar_column_select.sv
`timescale 1ns/1ps
`default_nettype none

module xbar_column_select
	import xbar_pkg::*;
#(
	parameter int DATA_WIDTH = 32
)(
	input  logic                                   clk,
	input  logic                                   i_arst_n,
	input  logic                                   i_en,
	input  logic [XBAR_N_HALF-1:0]                 i_valid,
	input  logic [XBAR_N_HALF-1:0][DATA_WIDTH-1:0] i_data,
	input  logic [XBAR_N_HALF-1:0]                 i_sel,
	output logic                                   o_valid,
	output logic [DATA_WIDTH-1:0]                  o_data
);

	logic                  sel_onehot;
	logic                  sel_valid;
	logic [DATA_WIDTH-1:0] sel_data;

	// exactly one bit set
	assign sel_onehot = (i_sel != '0) && ((i_sel & (i_sel - 1'b1)) == '0);

	// or-mux, only meaningful when the selector is one-hot
	always_comb
	begin
		sel_valid = 1'b0;
		sel_data  = '0;
		for (int k = 0; k < XBAR_N_HALF; k++)
		begin
			if (i_sel[k] && i_valid[k])
			begin
				sel_valid = 1'b1;
				sel_data  = sel_data | i_data[k];
			end
		end
	end

	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_valid <= 1'b0;
			o_data  <= '0;
		end
		else if (!i_en || !sel_onehot)   // disabled or bad column
		begin
			o_valid <= 1'b0;
			o_data  <= '0;
		end
		else
		begin
			o_valid <= sel_valid;
			o_data  <= sel_data;
		end
	end

	a_idle_data_zero: assert property (@(posedge clk) disable iff (!i_arst_n)
		!o_valid |-> o_data == '0);

endmodule

`default_nettype wire

//--- source/xbar_fanout_tree.sv
`timescale 1ns/1ps
`default_nettype none

module xbar_fanout_tree
	import xbar_pkg::*;
#(
	parameter int DATA_WIDTH = 32
)(
	input  logic                                  clk,
	input  logic                                  i_arst_n,
	input  logic                                  i_en,
	input  logic                                  i_valid,
	input  logic [DATA_WIDTH-1:0]                 i_data,
	output logic [XBAR_N_OUT-1:0]                 o_valid,
	output logic [XBAR_N_OUT-1:0][DATA_WIDTH-1:0] o_data
);

	genvar l, k;

	generate
		for (l = 0; l < XBAR_LEVELS; l++)
		begin : g_lvl
			localparam int COPIES = 1 << l;   // copies held at this level

			logic [COPIES-1:0]                 valid_q;
			logic [COPIES-1:0][DATA_WIDTH-1:0] data_q;

			if (l == 0)
			begin : g_first
				// only valid payload enters the tree
				always_ff @(posedge clk or negedge i_arst_n)
				begin
					if (!i_arst_n)
					begin
						valid_q <= '0;
						data_q  <= '0;
					end
					else if (!i_en)
					begin
						valid_q <= '0;
						data_q  <= '0;
					end
					else
					begin
						valid_q <= i_valid;
						data_q  <= i_valid ? i_data : '0;
					end
				end
			end
			else
			begin : g_double
				always_ff @(posedge clk or negedge i_arst_n)
				begin
					if (!i_arst_n)
					begin
						valid_q <= '0;
						data_q  <= '0;
					end
					else if (!i_en)
					begin
						valid_q <= '0;
						data_q  <= '0;
					end
					else
					begin
						valid_q <= {2{g_lvl[l-1].valid_q}};   // each copy feeds two
						data_q  <= {2{g_lvl[l-1].data_q}};
					end
				end
			end
		end
	endgenerate

	// last doubling lands in the output register
	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_valid <= '0;
			o_data  <= '0;
		end
		else if (!i_en)
		begin
			o_valid <= '0;
			o_data  <= '0;
		end
		else
		begin
			o_valid <= {2{g_lvl[XBAR_LEVELS-1].valid_q}};
			o_data  <= {2{g_lvl[XBAR_LEVELS-1].data_q}};
		end
	end

	generate
		for (k = 0; k < XBAR_N_OUT; k++)
		begin : g_chk
			a_idle_copy_zero: assert property (@(posedge clk) disable iff (!i_arst_n)
				!o_valid[k] |-> o_data[k] == '0);
		end
	endgenerate

endmodule

`default_nettype wire

//--- source/xbar_half_merge.sv
`timescale 1ns/1ps
`default_nettype none

module xbar_half_merge
	import xbar_pkg::*;
#(
	parameter int DATA_WIDTH = 32
)(
	input  logic                                  clk,
	input  logic                                  i_arst_n,
	input  logic                                  i_en,
	input  logic [XBAR_N_OUT-1:0]                 i_valid_lo,
	input  logic [XBAR_N_OUT-1:0]                 i_valid_hi,
	input  logic [XBAR_N_OUT-1:0][DATA_WIDTH-1:0] i_data_lo,
	input  logic [XBAR_N_OUT-1:0][DATA_WIDTH-1:0] i_data_hi,
	output logic [XBAR_N_OUT-1:0]                 o_valid,
	output logic [XBAR_N_OUT-1:0][DATA_WIDTH-1:0] o_data
);

	genvar o;

	always_ff @(posedge clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			o_valid <= '0;
			o_data  <= '0;
		end
		else if (!i_en)
		begin
			o_valid <= '0;
			o_data  <= '0;
		end
		else
		begin
			for (int k = 0; k < XBAR_N_OUT; k++)
			begin
				case ({i_valid_hi[k], i_valid_lo[k]})
					2'b01:
					begin
						o_valid[k] <= 1'b1;
						o_data[k]  <= i_data_lo[k];
					end
					2'b10:
					begin
						o_valid[k] <= 1'b1;
						o_data[k]  <= i_data_hi[k];
					end
					default:   // collision or nothing routed
					begin
						o_valid[k] <= 1'b0;
						o_data[k]  <= '0;
					end
				endcase
			end
		end
	end

	generate
		for (o = 0; o < XBAR_N_OUT; o++)
		begin : g_chk
			a_no_collision_out: assert property (@(posedge clk) disable iff (!i_arst_n)
				i_valid_lo[o] && i_valid_hi[o] |=> !o_valid[o]);
		end
	endgenerate

endmodule

`default_nettype wire

//--- source/xbar_pkg.sv
`default_nettype none

package xbar_pkg;

	// crossbar shape, fixed for the whole design
	localparam int XBAR_N_IN    = 16;
	localparam int XBAR_N_OUT   = 8;                  // power of two only
	localparam int XBAR_N_HALF  = XBAR_N_IN / 2;
	localparam int XBAR_LEVELS  = $clog2(XBAR_N_OUT);

	// in reg + tree levels + out reg, then column select and merge
	localparam int XBAR_LATENCY = XBAR_LEVELS + 3;

	// one-hot routing command
	// flat bit (n * XBAR_N_OUT + o) set when input n drives output o
	typedef union packed {
		logic [XBAR_N_IN*XBAR_N_OUT-1:0]      flat;
		logic [XBAR_N_IN-1:0][XBAR_N_OUT-1:0] by_input;  // per-input output mask
	} xbar_cmd_u;

endpackage

`default_nettype wire

//--- source/xbar_top.sv
`timescale 1ns/1ps
`default_nettype none

module xbar_top
	import xbar_pkg::*;
#(
	parameter int DATA_WIDTH = 32
)(
	input  logic                                  clk,
	input  logic                                  i_arst_n,
	input  logic                                  i_en,
	input  logic [XBAR_N_IN-1:0]                  i_valid,
	input  logic [XBAR_N_IN-1:0][DATA_WIDTH-1:0]  i_data,
	input  xbar_cmd_u                             i_cmd,
	output logic [XBAR_N_OUT-1:0]                 o_valid,
	output logic [XBAR_N_OUT-1:0][DATA_WIDTH-1:0] o_data
);

	// tree outputs, indexed [input][output]
	logic [XBAR_N_IN-1:0][XBAR_N_OUT-1:0]                 fan_valid;
	logic [XBAR_N_IN-1:0][XBAR_N_OUT-1:0][DATA_WIDTH-1:0] fan_data;
	logic [XBAR_N_IN-1:0][XBAR_N_OUT-1:0]                 cmd_sel;

	// column results, indexed [half][output]
	logic [1:0][XBAR_N_OUT-1:0]                 half_valid;
	logic [1:0][XBAR_N_OUT-1:0][DATA_WIDTH-1:0] half_data;

	genvar n, h, o, k;

	generate
		for (n = 0; n < XBAR_N_IN; n++)
		begin : g_in
			xbar_fanout_tree #(
				.DATA_WIDTH(DATA_WIDTH)
			) i_fanout (
				.clk      (clk),
				.i_arst_n (i_arst_n),
				.i_en     (i_en),
				.i_valid  (i_valid[n]),
				.i_data   (i_data[n]),
				.o_valid  (fan_valid[n]),
				.o_data   (fan_data[n])
			);

			xbar_cmd_tree i_cmd_tree (
				.clk      (clk),
				.i_arst_n (i_arst_n),
				.i_en     (i_en),
				.i_mask   (i_cmd.by_input[n]),
				.o_sel    (cmd_sel[n])
			);
		end

		for (h = 0; h < 2; h++)
		begin : g_half
			for (o = 0; o < XBAR_N_OUT; o++)
			begin : g_col
				logic [XBAR_N_HALF-1:0]                 col_valid;
				logic [XBAR_N_HALF-1:0][DATA_WIDTH-1:0] col_data;
				logic [XBAR_N_HALF-1:0]                 col_sel;

				// transpose: copy o of every input in this half
				for (k = 0; k < XBAR_N_HALF; k++)
				begin : g_tr
					assign col_valid[k] = fan_valid[h*XBAR_N_HALF+k][o];
					assign col_data[k]  = fan_data[h*XBAR_N_HALF+k][o];
					assign col_sel[k]   = cmd_sel[h*XBAR_N_HALF+k][o];
				end

				xbar_column_select #(
					.DATA_WIDTH(DATA_WIDTH)
				) i_col (
					.clk      (clk),
					.i_arst_n (i_arst_n),
					.i_en     (i_en),
					.i_valid  (col_valid),
					.i_data   (col_data),
					.i_sel    (col_sel),
					.o_valid  (half_valid[h][o]),
					.o_data   (half_data[h][o])
				);
			end
		end
	endgenerate

	xbar_half_merge #(
		.DATA_WIDTH(DATA_WIDTH)
	) i_merge (
		.clk        (clk),
		.i_arst_n   (i_arst_n),
		.i_en       (i_en),
		.i_valid_lo (half_valid[0]),
		.i_valid_hi (half_valid[1]),
		.i_data_lo  (half_data[0]),
		.i_data_hi  (half_data[1]),
		.o_valid    (o_valid),
		.o_data     (o_data)
	);

endmodule

`default_nettype wire
